//--- rtl/icache_tag_pkg.sv
/*
 * icache tag subsystem shared definitions
 * geometry of the 4-way, 64-set tag store, the tag entry layout,
 * the fetch address decode and the request/response structs
 */
package icache_tag_pkg;

    localparam int NUM_WAYS    = 4;
    localparam int WAY_BITS    = 2;
    localparam int SET_BITS    = 6;                   // same as the tag scm addr_width
    localparam int NUM_SETS    = 1 << SET_BITS;
    localparam int TAG_BITS    = 6;
    localparam int OFFSET_BITS = 4;
    localparam int ADDR_BITS   = TAG_BITS + SET_BITS + OFFSET_BITS;
    localparam int ENTRY_BITS  = 1 + TAG_BITS;        // same as the tag scm data_width

    // one stored tag line
    typedef struct packed {
        logic                valid;
        logic [TAG_BITS-1:0] tag;
    } tag_entry_t;

    // fetch address split, msb first
    typedef struct packed {
        logic [TAG_BITS-1:0]    tag;
        logic [SET_BITS-1:0]    set;
        logic [OFFSET_BITS-1:0] offset;
    } fetch_addr_t;

    // same word seen flat or by fields
    typedef union packed {
        logic [ADDR_BITS-1:0] raw;
        fetch_addr_t          fields;
    } fetch_addr_u;

    typedef struct packed {
        fetch_addr_u addr;
    } lookup_req_t;

    typedef struct packed {
        fetch_addr_u         addr;
        logic [WAY_BITS-1:0] way;  // way being refilled
    } fill_req_t;

    typedef struct packed {
        logic                hit;
        logic [WAY_BITS-1:0] way;  // hit way, or victim on a miss
        fetch_addr_u         addr; // echo of the looked-up address
    } lookup_rsp_t;

endpackage

//--- rtl/tag_reg_file.sv
/*
 * tag register file
 * 64 x 7 bit flop array, one read port and one write port,
 * read data registered on read enable and held otherwise
 */
`timescale 1ns/100ps

module tag_reg_file
(
    input  logic                                clk,
    input  logic                                read_enable,
    input  logic [icache_tag_pkg::SET_BITS-1:0] read_addr,
    output icache_tag_pkg::tag_entry_t          read_data,
    input  logic                                write_enable,
    input  logic [icache_tag_pkg::SET_BITS-1:0] write_addr,
    input  icache_tag_pkg::tag_entry_t          write_data
);

    // storage, valid bits come from the invalidate sweep
    logic [icache_tag_pkg::ENTRY_BITS-1:0] mem [icache_tag_pkg::NUM_SETS];

    // write port, visible to a read on the next edge
    always_ff @(posedge clk)
    begin
        if (write_enable)
        begin
            mem[write_addr] <= write_data;
        end
    end

    // registered read port
    always_ff @(posedge clk)
    begin
        if (read_enable)
        begin
            read_data <= mem[read_addr]; // keeps old value when idle
        end
    end

endmodule

//--- rtl/tag_ram_scm.sv
/*
 * single-port tag memory wrapper
 * maps a req/write access onto the 1r1w register file,
 * address and write data shared by both ports
 */
`timescale 1ns/100ps

module tag_ram_scm
(
    input  logic                                clk,
    input  logic                                req,
    input  logic                                write,
    input  logic [icache_tag_pkg::SET_BITS-1:0] addr,
    input  icache_tag_pkg::tag_entry_t          wdata,
    output icache_tag_pkg::tag_entry_t          rdata
);

    tag_reg_file i_tag_reg_file
    (
        .clk          ( clk           ),
        // read side
        .read_enable  ( req & ~write  ), // plain access is a read
        .read_addr    ( addr          ),
        .read_data    ( rdata         ),
        // write side
        .write_enable ( req & write   ),
        .write_addr   ( addr          ),
        .write_data   ( wdata         )
    );

endmodule

//--- rtl/victim_select.sv
/*
 * victim way selection
 * lowest invalid way first, round-robin pointer once the set is full
 */
`timescale 1ns/100ps

module victim_select
(
    input  logic                                clk,
    input  logic                                arst_n,
    input  logic [icache_tag_pkg::NUM_WAYS-1:0] entries_valid,
    input  logic                                advance,
    output logic [icache_tag_pkg::WAY_BITS-1:0] victim_way
);

    logic [icache_tag_pkg::WAY_BITS-1:0] rr_ptr; // next victim for a full set

    // pointer wraps naturally at 4 ways
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            rr_ptr <= '0;
        end
        else if (advance)
        begin
            rr_ptr <= rr_ptr + 1'b1;
        end
    end

    always_comb
    begin
        victim_way = rr_ptr; // default when every way is valid
        for (int i = icache_tag_pkg::NUM_WAYS - 1; i >= 0; i--)
        begin
            if (!entries_valid[i])
            begin
                victim_way = icache_tag_pkg::WAY_BITS'(i); // lowest index ends up last
            end
        end
    end

endmodule

//--- rtl/tag_lookup_ctrl.sv
/*
 * tag lookup controller
 * issues reads to all ways, compares the staged tag one cycle later,
 * writes refill entries into a single way and runs the invalidate
 * sweep after reset and on flush, holding busy while it runs
 */
`timescale 1ns/100ps

module tag_lookup_ctrl
(
    input  logic                                               clk,
    input  logic                                               arst_n,
    input  logic                                               lookup_valid,
    input  icache_tag_pkg::lookup_req_t                        lookup,
    input  logic                                               fill_valid,
    input  icache_tag_pkg::fill_req_t                          fill,
    input  logic                                               flush_valid,
    output logic [icache_tag_pkg::NUM_WAYS-1:0]                way_req,
    output logic [icache_tag_pkg::NUM_WAYS-1:0]                way_write,
    output logic [icache_tag_pkg::SET_BITS-1:0]                way_addr,
    output icache_tag_pkg::tag_entry_t                         way_wdata,
    input  icache_tag_pkg::tag_entry_t [icache_tag_pkg::NUM_WAYS-1:0] way_rdata,
    input  logic [icache_tag_pkg::WAY_BITS-1:0]                victim_way,
    output logic                                               advance,
    output logic                                               rsp_valid,
    output icache_tag_pkg::lookup_rsp_t                        rsp,
    output logic                                               busy
);

    logic                                sweep_active; // invalidate sweep running
    logic [icache_tag_pkg::SET_BITS-1:0] sweep_cnt;    // set being cleared
    logic                                lookup_take;
    logic                                fill_take;
    logic                                flush_take;
    icache_tag_pkg::fetch_addr_u         stage_addr;   // lookup address, one cycle late
    logic [icache_tag_pkg::NUM_WAYS-1:0] way_hit;
    logic [icache_tag_pkg::NUM_WAYS-1:0] way_valid;
    logic [icache_tag_pkg::WAY_BITS-1:0] hit_way;
    logic                                hit;

    assign busy        = sweep_active;
    assign lookup_take = lookup_valid & ~sweep_active; // strobes dropped while busy
    assign fill_take   = fill_valid & ~sweep_active;
    assign flush_take  = flush_valid & ~sweep_active;

    // sweep: starts out of reset, restarts on flush
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            sweep_active <= 1'b1;
            sweep_cnt    <= '0;
        end
        else if (sweep_active)
        begin
            sweep_cnt <= sweep_cnt + 1'b1;
            if (&sweep_cnt)
            begin
                sweep_active <= 1'b0; // last set cleared
            end
        end
        else if (flush_take)
        begin
            sweep_active <= 1'b1;
            sweep_cnt    <= '0;
        end
    end

    // memory port mux, sweep over fill over lookup
    always_comb
    begin
        way_req   = '0;
        way_write = '0;
        way_addr  = lookup.addr.fields.set;
        way_wdata = '0;                             // invalid entry for the sweep
        if (sweep_active)
        begin
            way_req   = '1;
            way_write = '1;
            way_addr  = sweep_cnt;
        end
        else if (fill_take)
        begin
            way_req[fill.way]   = 1'b1;             // chosen way only
            way_write[fill.way] = 1'b1;
            way_addr            = fill.addr.fields.set;
            way_wdata.valid     = 1'b1;
            way_wdata.tag       = fill.addr.fields.tag;
        end
        else if (lookup_take)
        begin
            way_req = '1;                           // read every way
        end
    end

    // response staging
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            rsp_valid <= 1'b0;
        end
        else
        begin
            rsp_valid <= lookup_take;
        end
    end

    always_ff @(posedge clk)
    begin
        if (lookup_take)
        begin
            stage_addr <= lookup.addr; // payload only
        end
    end

    // tag compare against the registered read data
    always_comb
    begin
        hit_way = '0;
        for (int i = 0; i < icache_tag_pkg::NUM_WAYS; i++)
        begin
            way_valid[i] = way_rdata[i].valid;
            way_hit[i]   = way_rdata[i].valid &&
                           (way_rdata[i].tag == stage_addr.fields.tag);
        end
        for (int i = icache_tag_pkg::NUM_WAYS - 1; i >= 0; i--)
        begin
            if (way_hit[i])
            begin
                hit_way = icache_tag_pkg::WAY_BITS'(i); // lowest match wins
            end
        end
        hit = |way_hit;
    end

    assign rsp.hit  = hit;
    assign rsp.way  = hit ? hit_way : victim_way;
    assign rsp.addr = stage_addr;

    // full-set miss moves the round-robin pointer
    assign advance = rsp_valid & ~hit & (&way_valid);

endmodule

//--- rtl/icache_tag_top.sv
/*
 * icache tag subsystem top
 * lookup controller and victim selector around four per-way
 * single-port tag memories
 */
`timescale 1ns/100ps

module icache_tag_top
(
    input  logic                        clk,
    input  logic                        arst_n,
    input  logic                        lookup_valid,
    input  icache_tag_pkg::lookup_req_t lookup,
    input  logic                        fill_valid,
    input  icache_tag_pkg::fill_req_t   fill,
    input  logic                        flush_valid,
    output logic                        rsp_valid,
    output icache_tag_pkg::lookup_rsp_t rsp,
    output logic                        busy
);

    logic [icache_tag_pkg::NUM_WAYS-1:0]                      way_req;
    logic [icache_tag_pkg::NUM_WAYS-1:0]                      way_write;
    logic [icache_tag_pkg::SET_BITS-1:0]                      way_addr;  // shared by all ways
    icache_tag_pkg::tag_entry_t                               way_wdata;
    icache_tag_pkg::tag_entry_t [icache_tag_pkg::NUM_WAYS-1:0] way_rdata;
    logic [icache_tag_pkg::NUM_WAYS-1:0]                      entries_valid;
    logic [icache_tag_pkg::WAY_BITS-1:0]                      victim_way;
    logic                                                     advance;

    tag_lookup_ctrl i_ctrl
    (
        .clk          ( clk          ),
        .arst_n       ( arst_n       ),
        .lookup_valid ( lookup_valid ),
        .lookup       ( lookup       ),
        .fill_valid   ( fill_valid   ),
        .fill         ( fill         ),
        .flush_valid  ( flush_valid  ),
        .way_req      ( way_req      ),
        .way_write    ( way_write    ),
        .way_addr     ( way_addr     ),
        .way_wdata    ( way_wdata    ),
        .way_rdata    ( way_rdata    ),
        .victim_way   ( victim_way   ),
        .advance      ( advance      ),
        .rsp_valid    ( rsp_valid    ),
        .rsp          ( rsp          ),
        .busy         ( busy         )
    );

    victim_select i_victim
    (
        .clk           ( clk           ),
        .arst_n        ( arst_n        ),
        .entries_valid ( entries_valid ),
        .advance       ( advance       ),
        .victim_way    ( victim_way    )
    );

    // one tag memory per way
    for (genvar g = 0; g < icache_tag_pkg::NUM_WAYS; g++)
    begin : gen_way
        assign entries_valid[g] = way_rdata[g].valid;

        tag_ram_scm i_tag_ram
        (
            .clk   ( clk          ),
            .req   ( way_req[g]   ),
            .write ( way_write[g] ),
            .addr  ( way_addr     ),
            .wdata ( way_wdata    ),
            .rdata ( way_rdata[g] )
        );
    end

endmodule

//--- test/icache_tag_assert.sv
/*
 * protocol assertions for the icache tag top level
 * strobe exclusivity, no strobes while busy, one-cycle lookup response
 */
`timescale 1ns/100ps

module icache_tag_assert
(
    input logic clk,
    input logic arst_n,
    input logic lookup_valid,
    input logic fill_valid,
    input logic flush_valid,
    input logic rsp_valid,
    input logic busy
);

    // lookup and fill share the tag port, no arbiter
    a_no_collision: assert property (@(posedge clk) disable iff (!arst_n)
        !(lookup_valid && fill_valid))
    else $error("lookup and fill strobes in the same cycle");

    // sweep owns the memories
    a_no_strobe_busy: assert property (@(posedge clk) disable iff (!arst_n)
        (lookup_valid || fill_valid || flush_valid) |-> !busy)
    else $error("request strobe while busy");

    a_rsp_after_lookup: assert property (@(posedge clk) disable iff (!arst_n)
        lookup_valid |=> rsp_valid)
    else $error("no response one cycle after lookup");

    a_rsp_only_after_lookup: assert property (@(posedge clk) disable iff (!arst_n)
        rsp_valid |-> $past(lookup_valid))
    else $error("response without a lookup one cycle earlier");

endmodule

bind icache_tag_top icache_tag_assert i_assert
(
    .clk          ( clk          ),
    .arst_n       ( arst_n       ),
    .lookup_valid ( lookup_valid ),
    .fill_valid   ( fill_valid   ),
    .flush_valid  ( flush_valid  ),
    .rsp_valid    ( rsp_valid    ),
    .busy         ( busy         )
);

//--- test/tb_icache_tag.sv
/*
 * testbench for the icache tag subsystem
 * replays the operation trace against the DUT, one op per cycle,
 * and checks every lookup response one cycle after its strobe
 */
`timescale 1ns/100ps

module tb_icache_tag;

    localparam int CLK_HALF     = 20; // 40 ns period
    localparam int SWEEP_CYCLES = 64; // one set per cycle

    typedef struct packed {
        logic [7:0]  op;      // ascii op code
        logic [15:0] addr;
        logic [1:0]  way;     // fill way
        logic        hit;     // expected hit
        logic [1:0]  exp_way; // expected hit or victim way
    } trace_op_t;

    logic                        clk = 1'b0;
    logic                        arst_n;
    logic                        lookup_valid;
    icache_tag_pkg::lookup_req_t lookup;
    logic                        fill_valid;
    icache_tag_pkg::fill_req_t   fill;
    logic                        flush_valid;
    logic                        rsp_valid;
    icache_tag_pkg::lookup_rsp_t rsp;
    logic                        busy;

    trace_op_t trace_q[$];
    int        flush_cnt   = 0;
    bit        trace_ready = 1'b0;

    always #CLK_HALF clk = ~clk;

    icache_tag_top i_dut
    (
        .clk          ( clk          ),
        .arst_n       ( arst_n       ),
        .lookup_valid ( lookup_valid ),
        .lookup       ( lookup       ),
        .fill_valid   ( fill_valid   ),
        .fill         ( fill         ),
        .flush_valid  ( flush_valid  ),
        .rsp_valid    ( rsp_valid    ),
        .rsp          ( rsp          ),
        .busy         ( busy         )
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("=== FAIL ===");
        $fatal(1, "simulation aborted");
    endtask

    task automatic report_mismatch(input string name, input int expected, input int actual);
        $display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
        $display("=== FAIL ===");
        $fatal(1, "value mismatch");
    endtask

    // five columns per op line
    task automatic load_trace();
        int        fd;
        int        c;
        int        a;
        int        w;
        int        h;
        int        ew;
        trace_op_t e;
        fd = $fopen("test/icache_tag_trace.txt", "r");
        if (fd == 0)
        begin
            abort_run("could not open the trace file test/icache_tag_trace.txt");
        end
        else
        begin
            c = $fgetc(fd);
            while (c != -1)
            begin
                if (c == "#")
                begin
                    while (c != "\n" && c != -1)
                    begin
                        c = $fgetc(fd); // skip rest of comment
                    end
                end
                else if (c == "L" || c == "F" || c == "X" || c == "W")
                begin
                    if ($fscanf(fd, " %h %d %d %d", a, w, h, ew) != 4)
                    begin
                        abort_run("malformed operation line in the trace file");
                    end
                    e.op      = 8'(c);
                    e.addr    = 16'(a);
                    e.way     = 2'(w);
                    e.hit     = 1'(h);
                    e.exp_way = 2'(ew);
                    trace_q.push_back(e);
                    if (c == "X")
                    begin
                        flush_cnt++;
                    end
                end
                else if (c != " " && c != "\n" && c != "\r" && c != "\t")
                begin
                    abort_run("unknown operation code in the trace file");
                end
                c = $fgetc(fd);
            end
            $fclose(fd);
            trace_ready = 1'b1;
        end
    endtask

    task automatic drive_idle();
        lookup_valid = 1'b0;
        fill_valid   = 1'b0;
        flush_valid  = 1'b0;
    endtask

    // sampled on the falling edge where rsp is stable
    task automatic check_response(input trace_op_t e, input int idx);
        string name;
        name = $sformatf("trace op %0d lookup %h", idx, e.addr);
        assert (rsp_valid)
        else abort_run($sformatf("no response one cycle after %s", name));
        assert (rsp.hit == e.hit)
        else report_mismatch({name, " hit"}, e.hit, rsp.hit);
        assert (rsp.way == e.exp_way)
        else report_mismatch({name, " way"}, e.exp_way, rsp.way);
        assert (rsp.addr.raw == e.addr)
        else report_mismatch({name, " addr echo"}, e.addr, rsp.addr.raw);
    endtask

    initial
    begin : main
        trace_op_t cur;
        trace_op_t pending;     // lookup awaiting its response
        int        pending_idx;
        bit        check_due;
        bit        flush_sent;  // flush issued since the last wait
        int        sweep_len;   // busy cycles counted in a wait
        int        exp_len;
        arst_n       = 1'b0;
        lookup_valid = 1'b0;
        lookup       = '0;
        fill_valid   = 1'b0;
        fill         = '0;
        flush_valid  = 1'b0;
        check_due    = 1'b0;
        flush_sent   = 1'b0;
        pending      = '0;
        pending_idx  = 0;
        load_trace();
        repeat (16) @(negedge clk);
        assert (busy && !rsp_valid)
        else abort_run("busy low or rsp_valid high during reset");
        arst_n    = 1'b1;
        sweep_len = 0;
        while (busy)
        begin
            @(negedge clk); // reset sweep
            sweep_len++;
        end
        assert (sweep_len == SWEEP_CYCLES)
        else report_mismatch("reset sweep busy cycles", SWEEP_CYCLES, sweep_len);
        for (int idx = 0; idx < trace_q.size(); idx++)
        begin
            cur = trace_q[idx];
            @(negedge clk);
            drive_idle();
            if (check_due)
            begin
                check_response(pending, pending_idx);
            end
            check_due = 1'b0;
            if (cur.op != "W")
            begin
                assert (!busy)
                else abort_run($sformatf("busy high when trace op %0d was due", idx));
            end
            case (cur.op)
                "L":
                begin
                    lookup_valid    = 1'b1;
                    lookup.addr.raw = cur.addr;
                    pending         = cur;
                    pending_idx     = idx;
                    check_due       = 1'b1;
                end
                "F":
                begin
                    fill_valid    = 1'b1;
                    fill.addr.raw = cur.addr;
                    fill.way      = cur.way;
                end
                "X":
                begin
                    flush_valid = 1'b1;
                    flush_sent  = 1'b1;
                end
                default:
                begin
                    sweep_len = 0;
                    while (busy)
                    begin
                        @(negedge clk); // flush sweep
                        sweep_len++;
                    end
                    exp_len = flush_sent ? SWEEP_CYCLES : 0;
                    assert (sweep_len == exp_len)
                    else report_mismatch($sformatf("trace op %0d flush busy cycles", idx),
                                         exp_len, sweep_len);
                    flush_sent = 1'b0;
                end
            endcase
        end
        @(negedge clk);
        drive_idle();
        if (check_due)
        begin
            check_response(pending, pending_idx);
        end
        $display("=== PASS ===");
        $finish;
    end

    // limit scales with sweeps and trace length
    initial
    begin : watchdog
        int limit;
        wait (trace_ready);
        limit = 16 + 64 * (flush_cnt + 1) + 4 * trace_q.size() + 100;
        repeat (limit) @(posedge clk);
        abort_run($sformatf("timeout, trace not finished after %0d cycles", limit));
    end

endmodule

//--- icache_tag_top.f
rtl/icache_tag_pkg.sv
rtl/tag_reg_file.sv
rtl/tag_ram_scm.sv
rtl/victim_select.sv
rtl/tag_lookup_ctrl.sv
rtl/icache_tag_top.sv
test/icache_tag_assert.sv
test/tb_icache_tag.sv

//--- Bender.yml
package:
  name: icache_tag

sources:
  # package first, then the tag store bottom up
  - rtl/icache_tag_pkg.sv
  - rtl/tag_reg_file.sv
  - rtl/tag_ram_scm.sv
  - rtl/victim_select.sv
  - rtl/tag_lookup_ctrl.sv
  - rtl/icache_tag_top.sv

  - target: test
    files:
      - test/icache_tag_assert.sv
      - test/tb_icache_tag.sv

//--- test/icache_tag_trace.txt
# columns: op addr(hex) way hit exp_way, way is the fill way, hit/exp_way the expected response
# op: L lookup, F fill, X flush, W wait for busy low; addr = tag[15:10] set[9:4] offset[3:0]
L 0450 0 0 0
L 0C20 0 0 0
F 0C20 1 0 0
L 0C20 0 1 1
L 0C25 0 1 1
L 1020 0 0 0
F 1020 0 0 0
L 1020 0 1 0
L 1420 0 0 2
F 2890 0 0 0
F 2C90 1 0 0
F 3090 2 0 0
F 3490 3 0 0
L 2C90 0 1 1
L 3490 0 1 3
L 289F 0 1 0
L 5090 0 0 0
L 5095 0 0 1
L 509A 0 0 2
L 5090 0 0 3
L 5090 0 0 0
X 0000 0 0 0
W 0000 0 0 0
L 0C20 0 0 0
L 3490 0 0 0
F FFF0 2 0 0
L FFF7 0 1 2
L FBF7 0 0 0
L FFE7 0 0 0
L 0C27 0 0 0
